// ==== hw/intervalTimer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_config.svh"

module intervalTimer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        loadEn,
    input  logic [`SYS_TIMER_WIDTH-1:0] loadValue,
    input  logic                        ack,
    output logic [`SYS_TIMER_WIDTH-1:0] count,
    output logic [`SYS_TIMER_WIDTH-1:0] reload,
    output logic                        pending
);

    localparam logic [`SYS_TIMER_WIDTH-1:0] COUNT_ONE = {{(`SYS_TIMER_WIDTH-1){1'b0}}, 1'b1};

    logic running;
    logic wrap;

    assign running = (reload != '0);       // zero reload stops the timer
    assign wrap    = running && (count == COUNT_ONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reload <= '0;
        end else if (loadEn) begin
            reload <= loadValue;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (loadEn) begin
            count <= loadValue;            // restart from the new period
        end else if (wrap) begin
            count <= reload;
        end else if (running && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // sticky until acknowledged, a new period wins over ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (wrap && !loadEn) begin
            pending <= 1'b1;
        end else if (ack) begin
            pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sysControlUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_config.svh"

module sysControlUnit import sysPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instrValid,
    input  sysInstr     instr,
    input  logic [31:0] operandB,
    input  logic [3:0]  resultFlags,
    output logic        instrReady,
    output logic        readValid,
    output logic [31:0] readData,
    output logic        irq,
    output logic [4:0]  trapCause,
    output logic [31:0] isrBaseAddress,
    output logic [3:0]  flags,
    output logic        interruptEnable,
    output logic [15:0] exceptionMask
);

    sysControl                   ctrl;
    logic                        exceptionPending;
    sysInstr                     curInstr;
    logic [31:0]                 curOperandB;
    logic [3:0]                  curFlags;
    logic                        timerPending;
    logic                        timerAck;
    logic                        timerLoadEn;
    logic [`SYS_TIMER_WIDTH-1:0] timerLoadValue;
    logic [`SYS_TIMER_WIDTH-1:0] timerCount;
    logic [`SYS_TIMER_WIDTH-1:0] timerReload;

    sysSequencer sequencer (
        .clk              (clk),
        .reset            (reset),
        .instrValid       (instrValid),
        .instr            (instr),
        .operandB         (operandB),
        .resultFlags      (resultFlags),
        .timerPending     (timerPending),
        .interruptEnable  (interruptEnable),
        .exceptionMask    (exceptionMask),
        .instrReady       (instrReady),
        .ctrl             (ctrl),
        .exceptionPending (exceptionPending),
        .cause            (trapCause),  // also the sys1 cause field
        .curInstr         (curInstr),
        .curOperandB      (curOperandB),
        .curFlags         (curFlags),
        .readValid        (readValid),
        .irq              (irq),
        .timerAck         (timerAck)
    );

    systemRegisters registers (
        .clk              (clk),
        .reset            (reset),
        .ctrl             (ctrl),
        .exceptionPending (exceptionPending),
        .instr            (curInstr),
        .operandB         (curOperandB),
        .resultFlags      (curFlags),
        .cause            (trapCause),
        .timerCount       (timerCount),
        .timerReload      (timerReload),
        .flags            (flags),
        .interruptEnable  (interruptEnable),
        .exceptionMask    (exceptionMask),
        .isrBaseAddress   (isrBaseAddress),
        .timerLoadEn      (timerLoadEn),
        .timerLoadValue   (timerLoadValue),
        .readData         (readData)
    );

    intervalTimer timer (
        .clk       (clk),
        .reset     (reset),
        .loadEn    (timerLoadEn),
        .loadValue (timerLoadValue),
        .ack       (timerAck),
        .count     (timerCount),
        .reload    (timerReload),
        .pending   (timerPending)
    );

endmodule

`default_nettype wire

// ==== hw/sysPkg.sv ====
`default_nettype none

package sysPkg;

    // opcodes in bits 31:26, everything else is illegal
    typedef enum logic [5:0] {
        OP_NOP     = 6'h00,
        OP_MTS     = 6'h30, // move to system register
        OP_MFS     = 6'h31, // move from system register
        OP_SETF    = 6'h32,
        OP_SYSCALL = 6'h33,
        OP_EI      = 6'h34,
        OP_DI      = 6'h35
    } sysOpcode;

    typedef enum logic {
        RESULT = 1'b0, // flags from the ALU result
        RFB    = 1'b1  // flags from register file port B
    } flagsSel;

    typedef enum logic [1:0] {
        LOAD  = 2'b00, // operandB bit 15
        CLEAR = 2'b01,
        SET   = 2'b10
    } intEnSel;

    typedef struct packed {
        logic    writeEn;
        logic    flagsEn;
        logic    systemCallEn;
        logic    intEnEn;
        intEnSel intEnSel;
        flagsSel flagsSel;
    } sysControl;

    localparam sysControl CTRL_NOP           = '{1'b0, 1'b0, 1'b0, 1'b0, LOAD,  RESULT};
    localparam sysControl CTRL_WRITE_DRL     = '{1'b1, 1'b0, 1'b0, 1'b0, LOAD,  RFB};
    localparam sysControl CTRL_WRITE_FLAGS   = '{1'b0, 1'b1, 1'b0, 1'b0, LOAD,  RESULT};
    localparam sysControl CTRL_WRITE_SYSCALL = '{1'b0, 1'b0, 1'b1, 1'b0, LOAD,  RESULT};
    localparam sysControl CTRL_CLEAR_INTEN   = '{1'b0, 1'b0, 1'b0, 1'b1, CLEAR, RESULT};
    localparam sysControl CTRL_SET_INTEN     = '{1'b0, 1'b0, 1'b0, 1'b1, SET,   RESULT};

    // register format
    typedef struct packed {
        sysOpcode    opcode;
        logic [4:0]  drl;    // destination system register
        logic [4:0]  spareA;
        logic [4:0]  srb;    // source system register
        logic [10:0] spareB;
    } regFormat;

    // immediate format, used by syscall
    typedef struct packed {
        sysOpcode    opcode;
        logic [19:0] spare;
        logic [5:0]  imm6;
    } immFormat;

    typedef union packed {
        regFormat r;
        immFormat i;
    } sysInstr;

endpackage

`default_nettype wire

// ==== hw/sysSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_config.svh"

module sysSequencer import sysPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instrValid,
    input  sysInstr     instr,
    input  logic [31:0] operandB,
    input  logic [3:0]  resultFlags,
    input  logic        timerPending,
    input  logic        interruptEnable,
    input  logic [15:0] exceptionMask,
    output logic        instrReady,
    output sysControl   ctrl,
    output logic        exceptionPending,
    output logic [4:0]  cause,
    output sysInstr     curInstr,
    output logic [31:0] curOperandB,
    output logic [3:0]  curFlags,
    output logic        readValid,
    output logic        irq,
    output logic        timerAck
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        TRAP
    } seqState;

    seqState    state;
    seqState    stateNext;
    logic       running;   // first cycle out of reset keeps ready low
    logic       trapDue;
    logic       accept;
    sysControl  execCtrl;
    logic       execException;
    logic [4:0] execCause;
    logic       execRead;

    assign trapDue    = timerPending && interruptEnable && exceptionMask[`SYS_TIMER_MASK_BIT];
    assign instrReady = running && (state == IDLE) && !trapDue;
    assign accept     = instrValid && instrReady;

    // issue port latch, only one instruction in flight
    always_ff @(posedge clk) begin
        if (accept) begin
            curInstr    <= instr;
            curOperandB <= operandB;
            curFlags    <= resultFlags;
        end
    end

    // opcode decode of the latched word
    always_comb begin
        execCtrl      = CTRL_NOP;
        execException = 1'b0;
        execCause     = `SYS_CAUSE_NONE;
        execRead      = 1'b0;
        case (curInstr.r.opcode)
            OP_NOP:  execCtrl = CTRL_NOP;
            OP_MTS:  execCtrl = CTRL_WRITE_DRL;
            OP_MFS:  execRead = 1'b1;
            OP_SETF: execCtrl = CTRL_WRITE_FLAGS;
            OP_SYSCALL: begin
                execCtrl      = CTRL_WRITE_SYSCALL;
                execException = 1'b1;
                execCause     = `SYS_CAUSE_SYSCALL;
            end
            OP_EI:   execCtrl = CTRL_SET_INTEN;
            OP_DI:   execCtrl = CTRL_CLEAR_INTEN;
            default: begin
                execException = 1'b1;
                execCause     = `SYS_CAUSE_ILLEGAL;
            end
        endcase
    end

    always_comb begin
        ctrl             = CTRL_NOP;
        exceptionPending = 1'b0;
        readValid        = 1'b0;
        irq              = 1'b0;
        timerAck         = 1'b0;
        case (state)
            EXEC: begin
                ctrl             = execCtrl;
                exceptionPending = execException;
                readValid        = execRead;
            end
            TRAP: begin
                ctrl     = CTRL_CLEAR_INTEN;   // no nested interrupts
                irq      = 1'b1;
                timerAck = (cause == `SYS_CAUSE_TIMER);
            end
            default: ;
        endcase
    end

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (trapDue) stateNext = TRAP; // trap before new work
                else if (accept) stateNext = EXEC;
            end
            EXEC:    stateNext = execException ? TRAP : IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            running <= 1'b0;
        end else begin
            state   <= stateNext;
            running <= 1'b1;
        end
    end

    // cause is set on the way into TRAP so it is valid during irq
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cause <= `SYS_CAUSE_NONE;
        end else if (state == IDLE && trapDue) begin
            cause <= `SYS_CAUSE_TIMER;
        end else if (state == EXEC && execException) begin
            cause <= execCause;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sys_config.svh ====
`ifndef SYS_CONFIG_SVH
`define SYS_CONFIG_SVH

// ISR base address after reset
`define SYS_ISR_RESET       32'd4

// trap cause codes, one-hot above NONE
`define SYS_CAUSE_NONE      5'd0
`define SYS_CAUSE_ILLEGAL   5'd2
`define SYS_CAUSE_SYSCALL   5'd8
`define SYS_CAUSE_TIMER     5'd16

// exception mask bit that lets the timer interrupt through
`define SYS_TIMER_MASK_BIT  0

// interval timer counter width
`define SYS_TIMER_WIDTH     16

`endif

// ==== hw/systemRegisters.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_config.svh"

module systemRegisters import sysPkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  sysControl                   ctrl,
    input  logic                        exceptionPending,
    input  sysInstr                     instr,
    input  logic [31:0]                 operandB,
    input  logic [3:0]                  resultFlags,
    input  logic [4:0]                  cause,
    input  logic [`SYS_TIMER_WIDTH-1:0] timerCount,
    input  logic [`SYS_TIMER_WIDTH-1:0] timerReload,
    output logic [3:0]                  flags,
    output logic                        interruptEnable,
    output logic [15:0]                 exceptionMask,
    output logic [31:0]                 isrBaseAddress,
    output logic                        timerLoadEn,
    output logic [`SYS_TIMER_WIDTH-1:0] timerLoadValue,
    output logic [31:0]                 readData
);

    logic       writeOk;
    logic       flagsWr;
    logic       intEnWr;
    logic       maskWr;
    logic       isrBaseWr;
    logic [3:0] flagsNext;
    logic       intEnNext;
    logic [5:0] systemCall;

    assign writeOk        = ctrl.writeEn && !exceptionPending;
    assign timerLoadValue = operandB[`SYS_TIMER_WIDTH-1:0];

    // write decoder, DRL picks the target
    always_comb begin
        flagsWr     = 1'b0;
        intEnWr     = 1'b0;
        maskWr      = 1'b0;
        isrBaseWr   = 1'b0;
        timerLoadEn = 1'b0;
        if (writeOk) begin
            case (instr.r.drl)
                5'd0: flagsWr = 1'b1;
                5'd1: begin
                    intEnWr = 1'b1; // sys1 carries both
                    maskWr  = 1'b1;
                end
                5'd2: isrBaseWr = 1'b1;
                5'd4: timerLoadEn = 1'b1;
                default: ;          // read-only or unmapped
            endcase
        end
        // setf / ei / di paths
        if (ctrl.flagsEn && !exceptionPending) flagsWr = 1'b1;
        if (ctrl.intEnEn && !exceptionPending) intEnWr = 1'b1;
    end

    always_comb begin
        case (ctrl.flagsSel)
            RFB:     flagsNext = operandB[3:0];
            default: flagsNext = resultFlags;
        endcase
    end

    always_comb begin
        case (ctrl.intEnSel)
            CLEAR:   intEnNext = 1'b0;
            SET:     intEnNext = 1'b1;
            default: intEnNext = operandB[15];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= 4'b0;
        end else if (flagsWr) begin
            flags <= flagsNext;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interruptEnable <= 1'b0;
            exceptionMask   <= 16'b0;
        end else begin
            if (intEnWr) interruptEnable <= intEnNext;
            if (maskWr)  exceptionMask   <= operandB[31:16];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            isrBaseAddress <= `SYS_ISR_RESET;
        end else if (isrBaseWr) begin
            isrBaseAddress <= operandB;
        end
    end

    // syscall number is kept even though the syscall traps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            systemCall <= 6'b0;
        end else if (ctrl.systemCallEn) begin
            systemCall <= instr.i.imm6;
        end
    end

    // read mux on SRB
    always_comb begin
        case (instr.r.srb)
            5'd0:    readData = {28'b0, flags};
            5'd1:    readData = {exceptionMask, interruptEnable, 10'b0, cause};
            5'd2:    readData = isrBaseAddress;
            5'd3:    readData = {26'b0, systemCall};
            5'd4:    readData = {{(32-`SYS_TIMER_WIDTH){1'b0}}, timerReload};
            5'd5:    readData = {{(32-`SYS_TIMER_WIDTH){1'b0}}, timerCount};
            default: readData = 32'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/sysPkg.sv
hw/intervalTimer.sv
hw/systemRegisters.sv
hw/sysSequencer.sv
hw/sysControlUnit.sv
verification/clockGen.sv
verification/sysControlUnit_tb.sv

// ==== verification/clockGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // held for 10 rising edges, released just after the edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/sysControlUnit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sys_config.svh"

module sysControlUnit_tb import sysPkg::*; ();

    localparam int READY_LIMIT  = 50;
    localparam int TIMER_PERIOD = 8;

    logic        clk;
    logic        reset;
    logic        instrValid;
    sysInstr     instr;
    logic [31:0] operandB;
    logic [3:0]  resultFlags;
    logic        instrReady;
    logic        readValid;
    logic [31:0] readData;
    logic        irq;
    logic [4:0]  trapCause;
    logic [31:0] isrBaseAddress;
    logic [3:0]  flags;
    logic        interruptEnable;
    logic [15:0] exceptionMask;

    // reference model of the system registers
    logic [3:0]  expFlags;
    logic        expIntEn;
    logic [15:0] expMask;
    logic [31:0] expIsr;
    logic [15:0] expReload;
    logic [5:0]  expSyscall;
    logic [4:0]  expCause;

    logic [31:0] lfsrState   = 32'hfb24_e961;
    int          issueCount  = 0;
    int          acceptCount = 0;
    int          readCount   = 0;

    clockGen clocks (.clk(clk), .reset(reset));

    sysControlUnit DUT (
        .clk             (clk),
        .reset           (reset),
        .instrValid      (instrValid),
        .instr           (instr),
        .operandB        (operandB),
        .resultFlags     (resultFlags),
        .instrReady      (instrReady),
        .readValid       (readValid),
        .readData        (readData),
        .irq             (irq),
        .trapCause       (trapCause),
        .isrBaseAddress  (isrBaseAddress),
        .flags           (flags),
        .interruptEnable (interruptEnable),
        .exceptionMask   (exceptionMask)
    );

    task automatic stopRun();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    noReadyDuringOutput: assert property (@(posedge clk) disable iff (reset)
        !(instrReady && (irq || readValid)))
        else begin
            $display("instrReady was high while irq or readValid was high");
            stopRun();
        end

    irqSingleCycle: assert property (@(posedge clk) disable iff (reset) irq |=> !irq)
        else begin
            $display("irq stayed high for more than one cycle");
            stopRun();
        end

    // handshakes and read pulses counted at the edge
    always @(posedge clk) begin
        if (!reset && instrValid && instrReady) acceptCount++;
        if (!reset && readValid) readCount++;
    end

    // fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int k = 0; k < width; k++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic sysInstr regInstr(input sysOpcode op, input logic [4:0] drl,
                                         input logic [4:0] srb);
        sysInstr word;
        word          = '0;
        word.r.opcode = op;
        word.r.drl    = drl;
        word.r.srb    = srb;
        return word;
    endfunction

    function automatic sysInstr immInstr(input sysOpcode op, input logic [5:0] imm);
        sysInstr word;
        word          = '0;
        word.i.opcode = op;
        word.i.spare  = 20'(randomBits(20));   // ignored by syscall
        word.i.imm6   = imm;
        return word;
    endfunction

    // mask in 31:16 and enable in bit 15 above the cause field
    function automatic logic [31:0] packSys1();
        return {expMask, expIntEn, 10'b0, expCause};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual)
            else begin
                $display("FAIL %s expected %h actual %h", name, expected, actual);
                stopRun();
            end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // returns in the EXEC cycle one cycle after acceptance
    task automatic issue(input sysInstr word, input logic [31:0] b, input logic [3:0] f);
        int waited;
        instr       = word;
        operandB    = b;
        resultFlags = f;
        instrValid  = 1'b1;
        waited      = 0;
        while (!instrReady) begin
            tick();
            waited++;
            if (waited > READY_LIMIT) begin
                $display("timeout: instrReady never came back");
                stopRun();
            end
        end
        tick();                  // acceptance edge
        instrValid = 1'b0;
        issueCount++;
    endtask

    task automatic writeSys(input logic [4:0] index, input logic [31:0] b);
        issue(regInstr(OP_MTS, index, 5'd0), b, 4'(randomBits(4)));
        tick();                  // write lands at the end of EXEC
    endtask

    task automatic readSys(input string name, input logic [4:0] index,
                           input logic [31:0] expected);
        issue(regInstr(OP_MFS, 5'(randomBits(5)), index), randomBits(32), 4'h0);
        checkValue({name, " valid"}, 32'd1, readValid);
        checkValue(name, expected, readData);
        tick();
        checkValue({name, " valid drop"}, 32'd0, readValid);
    endtask

    // waits for irq then checks cause and the cleared enable
    task automatic expectTrap(input string name, input logic [4:0] cause, input int limit,
                              output int latency);
        latency = 0;
        while (!irq) begin
            tick();
            latency++;
            if (latency > limit) begin
                $display("timeout: no irq for %s", name);
                stopRun();
            end
        end
        checkValue({name, " cause"}, cause, trapCause);
        expCause = cause;
        expIntEn = 1'b0;
        tick();
        checkValue({name, " enable cleared"}, expIntEn, interruptEnable);
    endtask

    initial begin
        logic [31:0] b;
        sysInstr     word;
        int          waited;
        int          reads;
        instrValid  = 1'b0;
        instr       = '0;
        operandB    = '0;
        resultFlags = '0;
        expFlags    = '0;
        expIntEn    = 1'b0;
        expMask     = '0;
        expIsr      = `SYS_ISR_RESET;
        expReload   = '0;
        expSyscall  = '0;
        expCause    = `SYS_CAUSE_NONE;
        #1;
        checkValue("ready in reset", 32'd0, instrReady);
        waited = 0;
        while (reset) begin
            tick();
            waited++;
            if (waited > 20) begin
                $display("timeout: reset was never released");
                stopRun();
            end
        end
        tick();

        // 1. reset values
        checkValue("reset flags", expFlags, flags);
        checkValue("reset enable", expIntEn, interruptEnable);
        checkValue("reset mask", expMask, exceptionMask);
        checkValue("reset isr", expIsr, isrBaseAddress);
        checkValue("reset irq", 32'd0, irq);
        checkValue("reset readValid", 32'd0, readValid);

        // 2. move to / move from round trip
        for (int n = 0; n < 4; n++) begin
            b = randomBits(32);
            writeSys(5'd0, b);
            expFlags = b[3:0];
            b = randomBits(32);
            b[16 + `SYS_TIMER_MASK_BIT] = 1'b0;  // timer stays masked here
            writeSys(5'd1, b);
            expMask  = b[31:16];
            expIntEn = b[15];
            b = randomBits(32);
            writeSys(5'd2, b);
            expIsr = b;
            b = randomBits(16);
            writeSys(5'd4, b);
            expReload = b[15:0];
            readSys("mfs sys0", 5'd0, {28'b0, expFlags});
            readSys("mfs sys1", 5'd1, packSys1());
            readSys("mfs sys2", 5'd2, expIsr);
            readSys("mfs sys4", 5'd4, {16'b0, expReload});
            checkValue("mts flags", expFlags, flags);
            checkValue("mts enable", expIntEn, interruptEnable);
            checkValue("mts mask", expMask, exceptionMask);
            checkValue("mts isr", expIsr, isrBaseAddress);
        end
        readSys("mfs sys6", 5'd6, 32'd0);
        readSys("mfs sys7", 5'd7, 32'd0);
        readSys("mfs sys31", 5'd31, 32'd0);

        // 3. setf, ei, di
        b = randomBits(4);
        issue(regInstr(OP_SETF, 5'd0, 5'd0), randomBits(32), b[3:0]);
        checkValue("setf during exec", expFlags, flags);
        tick();
        expFlags = b[3:0];
        checkValue("setf flags", expFlags, flags);
        issue(regInstr(OP_EI, 5'd0, 5'd0), 32'd0, 4'h0);
        tick();
        expIntEn = 1'b1;
        checkValue("ei enable", expIntEn, interruptEnable);
        issue(regInstr(OP_DI, 5'd0, 5'd0), 32'hffff_ffff, 4'h0);
        tick();
        expIntEn = 1'b0;
        checkValue("di enable", expIntEn, interruptEnable);

        // 4. syscall and illegal opcode
        issue(regInstr(OP_EI, 5'd0, 5'd0), 32'd0, 4'h0);
        tick();
        expIntEn = 1'b1;
        checkValue("ei after di", expIntEn, interruptEnable);
        word = immInstr(OP_SYSCALL, 6'(randomBits(6)));
        issue(word, randomBits(32), 4'(randomBits(4)));
        checkValue("syscall irq early", 32'd0, irq);
        expectTrap("syscall", `SYS_CAUSE_SYSCALL, 3, waited);
        checkValue("syscall irq latency", 32'd1, waited);
        expSyscall = word.i.imm6;
        readSys("mfs sys3", 5'd3, {26'b0, expSyscall});
        readSys("mfs sys1 after syscall", 5'd1, packSys1());
        word          = randomBits(32);
        word.r.opcode = sysOpcode'(6'h3f);
        issue(word, randomBits(32), 4'(randomBits(4)));
        expectTrap("illegal", `SYS_CAUSE_ILLEGAL, 3, waited);
        checkValue("illegal irq latency", 32'd1, waited);
        checkValue("illegal flags", expFlags, flags);
        checkValue("illegal mask", expMask, exceptionMask);
        checkValue("illegal isr", expIsr, isrBaseAddress);
        readSys("illegal sys3", 5'd3, {26'b0, expSyscall});
        readSys("illegal sys4", 5'd4, {16'b0, expReload});

        // 5. timer trap and then the masked timer
        writeSys(5'd4, TIMER_PERIOD);
        expReload = 16'(TIMER_PERIOD);
        writeSys(5'd1, {16'd1 << `SYS_TIMER_MASK_BIT, 1'b1, 15'b0});
        expMask  = 16'd1 << `SYS_TIMER_MASK_BIT;
        expIntEn = 1'b1;
        expectTrap("timer", `SYS_CAUSE_TIMER, TIMER_PERIOD + 10, waited);
        readSys("mfs sys1 after timer", 5'd1, packSys1());
        writeSys(5'd1, {16'd0, 1'b1, 15'b0});
        expMask  = 16'd0;
        expIntEn = 1'b1;
        for (int n = 0; n < 2 * TIMER_PERIOD; n++) begin
            checkValue("masked timer irq", 32'd0, irq);
            tick();
        end
        issue(regInstr(OP_DI, 5'd0, 5'd0), 32'd0, 4'h0);
        tick();
        expIntEn = 1'b0;
        writeSys(5'd4, 32'd0);                 // stop the timer
        expReload = '0;

        // 6. back-pressure with mfs held through EXEC and TRAP
        reads = readCount;
        word  = immInstr(OP_SYSCALL, 6'(randomBits(6)));
        issue(word, 32'd0, 4'h0);
        issue(regInstr(OP_MFS, 5'd0, 5'd3), 32'd0, 4'h0);
        expSyscall = word.i.imm6;
        expCause   = `SYS_CAUSE_SYSCALL;
        checkValue("held mfs valid", 32'd1, readValid);
        checkValue("held mfs data", {26'b0, expSyscall}, readData);
        tick();
        checkValue("held mfs read once", reads + 1, readCount);
        readSys("mfs sys1 final", 5'd1, packSys1());
        checkValue("accepted once each", issueCount, acceptCount);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
